//--- src/tinker_pkg.sv
`default_nettype none

package tinker_pkg;

    // datapath widths
    localparam int XLEN    = 64;
    localparam int INSTR_W = 32;
    localparam int REG_AW  = 5;
    localparam int LIT_W   = 12;

    // kept integer opcodes with reference encodings
    typedef enum logic [4:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,
        op_shftri = 5'b00101,
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_mov    = 5'b10001,
        op_mov_l  = 5'b10010,
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011,
        op_mul    = 5'b11100
    } opcode_e;

    // one decoded operation as it travels through the fifo
    typedef struct packed {
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [LIT_W-1:0]  lit;
        // second operand comes from the literal
        logic              use_lit;
    } dec_op_t;

    // register write-back that also goes out on the result stream
    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   value;
    } wb_t;

endpackage

`default_nettype wire

//--- src/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  logic                          instr_valid,
    output logic                          instr_ready,
    input  logic [tinker_pkg::INSTR_W-1:0] instr,
    output logic                          push_valid,
    input  logic                          push_ready,
    output tinker_pkg::dec_op_t           push_op
);

    tinker_pkg::opcode_e opc;
    logic                legal;
    logic                use_lit;

    // opcode sits in the top five bits
    assign opc = tinker_pkg::opcode_e'(instr[31:27]);

    // classify legality and whether the literal replaces rt
    always_comb begin
        legal   = 1'b1;
        use_lit = 1'b0;
        case (opc)
            tinker_pkg::op_addi,
            tinker_pkg::op_subi,
            tinker_pkg::op_shftri,
            tinker_pkg::op_shftli,
            tinker_pkg::op_mov_l: use_lit = 1'b1;
            tinker_pkg::op_add,
            tinker_pkg::op_sub,
            tinker_pkg::op_mul,
            tinker_pkg::op_and,
            tinker_pkg::op_or,
            tinker_pkg::op_xor,
            tinker_pkg::op_not,
            tinker_pkg::op_shftr,
            tinker_pkg::op_shftl,
            tinker_pkg::op_mov: use_lit = 1'b0;
            // anything else is dropped
            default: legal = 1'b0;
        endcase
    end

    // field split per reference layout
    always_comb begin
        push_op.op      = opc;
        push_op.rd      = instr[26:22];
        push_op.rs      = instr[21:17];
        push_op.rt      = instr[16:12];
        push_op.lit     = instr[11:0];
        push_op.use_lit = use_lit;
    end

    // illegal words are consumed without a push
    assign instr_ready = push_ready;
    assign push_valid  = instr_valid && legal;

endmodule

`default_nettype wire

//--- src/op_fifo.sv
`default_nettype none

module op_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push_valid,
    output logic                push_ready,
    input  tinker_pkg::dec_op_t push_op,
    output logic                op_valid,
    input  logic                op_ready,
    output tinker_pkg::dec_op_t op
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    tinker_pkg::dec_op_t mem [DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic                do_push;
    logic                do_pop;

    assign push_ready = (count != CW'(DEPTH));
    assign op_valid   = (count != '0);
    assign do_push    = push_valid && push_ready;
    assign do_pop     = op_valid && op_ready;

    // head of queue straight from storage
    assign op = mem[rd_ptr];

    // payload storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_op;
        end
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // a push into a full queue would carry count past DEPTH
    assert property (@(posedge clk) disable iff (reset)
        (count == CW'(DEPTH)) |=> (count != '0 && count <= CW'(DEPTH)));

    // a pop from an empty queue would wrap count around
    assert property (@(posedge clk) disable iff (reset)
        (count == '0) |=> (count <= CW'(1)));

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [tinker_pkg::REG_AW-1:0]  rs_addr,
    input  logic [tinker_pkg::REG_AW-1:0]  rt_addr,
    input  logic [tinker_pkg::REG_AW-1:0]  rd_addr,
    output logic [tinker_pkg::XLEN-1:0]    rs_val,
    output logic [tinker_pkg::XLEN-1:0]    rt_val,
    output logic [tinker_pkg::XLEN-1:0]    rd_val,
    input  logic                           we,
    input  logic [tinker_pkg::REG_AW-1:0]  wr_addr,
    input  logic [tinker_pkg::XLEN-1:0]    wr_data
);

    localparam int NREGS = 2 ** tinker_pkg::REG_AW;

    logic [tinker_pkg::XLEN-1:0] regs [NREGS];

    // three async read ports give the old value until the write edge
    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];
    assign rd_val = regs[rd_addr];

    // every register starts at zero, r31 included
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`default_nettype none

module exec_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                op_valid,
    output logic                op_ready,
    input  tinker_pkg::dec_op_t op,
    output logic                wb_valid,
    input  logic                wb_ready,
    output tinker_pkg::wb_t     wb
);

    logic [tinker_pkg::XLEN-1:0] rs_val;
    logic [tinker_pkg::XLEN-1:0] rt_val;
    logic [tinker_pkg::XLEN-1:0] rd_val;
    logic [tinker_pkg::XLEN-1:0] opa;
    logic [tinker_pkg::XLEN-1:0] opb;
    logic [tinker_pkg::XLEN-1:0] lit_sx;
    logic [tinker_pkg::XLEN-1:0] result;
    logic                        pop;
    tinker_pkg::wb_t             wb_next;

    // take a new op when the output slot is empty or draining
    assign op_ready = !wb_valid || wb_ready;
    assign pop      = op_valid && op_ready;

    // operands read here and written back at the same edge
    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (op.rs),
        .rt_addr (op.rt),
        .rd_addr (op.rd),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .rd_val  (rd_val),
        .we      (pop),
        .wr_addr (op.rd),
        .wr_data (result)
    );

    assign lit_sx = {{(tinker_pkg::XLEN - tinker_pkg::LIT_W){op.lit[tinker_pkg::LIT_W-1]}},
                     op.lit};

    // addi, subi and mov_l work on the old rd
    always_comb begin
        case (op.op)
            tinker_pkg::op_addi,
            tinker_pkg::op_subi,
            tinker_pkg::op_mov_l: opa = rd_val;
            default:              opa = rs_val;
        endcase
    end

    assign opb = op.use_lit ? lit_sx : rt_val;

    // shifts use all 64 bits of opb, so >= 64 clears the result
    always_comb begin
        case (op.op)
            tinker_pkg::op_add,
            tinker_pkg::op_addi:   result = opa + opb;
            tinker_pkg::op_sub,
            tinker_pkg::op_subi:   result = opa - opb;
            tinker_pkg::op_mul:    result = opa * opb;
            tinker_pkg::op_and:    result = opa & opb;
            tinker_pkg::op_or:     result = opa | opb;
            tinker_pkg::op_xor:    result = opa ^ opb;
            tinker_pkg::op_not:    result = ~opa;
            tinker_pkg::op_shftr,
            tinker_pkg::op_shftri: result = opa >> opb;
            tinker_pkg::op_shftl,
            tinker_pkg::op_shftli: result = opa << opb;
            tinker_pkg::op_mov:    result = opa;
            // upper bits of rd kept, low 12 from literal
            tinker_pkg::op_mov_l:  result = {opa[tinker_pkg::XLEN-1:tinker_pkg::LIT_W],
                                             opb[tinker_pkg::LIT_W-1:0]};
            default:               result = '0;
        endcase
    end

    assign wb_next = '{rd: op.rd, value: result};

    // output slot valid flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (pop) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    // output payload loaded on each pop
    always_ff @(posedge clk) begin
        if (pop) begin
            wb <= wb_next;
        end
    end

    // stalled result must hold until taken
    assert property (@(posedge clk) disable iff (reset)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb)));

endmodule

`default_nettype wire

//--- src/tinker_exec_top.sv
`default_nettype none

module tinker_exec_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           instr_valid,
    output logic                           instr_ready,
    input  logic [tinker_pkg::INSTR_W-1:0] instr,
    output logic                           wb_valid,
    input  logic                           wb_ready,
    output tinker_pkg::wb_t                wb
);

    // decoder to fifo
    logic                push_valid;
    logic                push_ready;
    tinker_pkg::dec_op_t push_op;

    // fifo to execute
    logic                op_valid;
    logic                op_ready;
    tinker_pkg::dec_op_t op;

    instr_decoder u_decoder (
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .push_valid  (push_valid),
        .push_ready  (push_ready),
        .push_op     (push_op)
    );

    op_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_op    (push_op),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .op         (op)
    );

    exec_unit u_exec (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb       (wb)
    );

endmodule

`default_nettype wire

//--- verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// opcode tag plus result value for each write-back
typedef struct packed {
    tinker_pkg::opcode_e         op;
    logic [tinker_pkg::XLEN-1:0] value;
} trace_t;

// wrong value seen on the output
task automatic value_error(input string msg);
    $display("ERR %0d ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "value mismatch");
endtask

// hang or protocol problem
task automatic run_error(input string msg);
    $display("%0d ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "run aborted");
endtask

// full write-back with register and value
task automatic check_wb(input tinker_pkg::wb_t got, input tinker_pkg::wb_t exp);
    if (got !== exp) begin
        value_error($sformatf("write-back r%0d = %h, expected r%0d = %h",
                              got.rd, got.value, exp.rd, exp.value));
    end
endtask

// value against the op that made it
task automatic check_trace(input trace_t got, input trace_t exp);
    if (got !== exp) begin
        value_error($sformatf("%s gave %h, expected %h",
                              exp.op.name(), got.value, exp.value));
    end
endtask

`endif

//--- verif/tb_tinker_exec.sv
`default_nettype none

module tb_tinker_exec;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic                           clk;
    logic                           reset;
    logic                           instr_valid;
    logic                           instr_ready;
    logic [tinker_pkg::INSTR_W-1:0] instr;
    logic                           wb_valid;
    logic                           wb_ready;
    tinker_pkg::wb_t                wb;

    // reference registers, program and expected results
    logic [tinker_pkg::XLEN-1:0]    model [32];
    logic [tinker_pkg::INSTR_W-1:0] prog [$];
    tinker_pkg::wb_t                exp_wb [$];
    tinker_pkg::opcode_e            exp_op [$];

    // arith first, then logic and shifts, then moves
    tinker_pkg::opcode_e all_ops [15] = '{tinker_pkg::op_add, tinker_pkg::op_addi,
        tinker_pkg::op_sub, tinker_pkg::op_subi, tinker_pkg::op_mul, tinker_pkg::op_and,
        tinker_pkg::op_or, tinker_pkg::op_xor, tinker_pkg::op_not, tinker_pkg::op_shftr,
        tinker_pkg::op_shftri, tinker_pkg::op_shftl, tinker_pkg::op_shftli,
        tinker_pkg::op_mov, tinker_pkg::op_mov_l};

    `include "tb_checks.svh"

    tinker_exec_top #(.FIFO_DEPTH(4)) dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc(input tinker_pkg::opcode_e op, input int rd,
                                        input int rs, input int rt, input logic [11:0] lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    // reference model on raw opcode bits
    function automatic void queue_instr(input logic [31:0] w);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] lit;
        logic [63:0] r;
        logic [4:0]  rd;
        logic        ok;
        rd  = w[26:22];
        a   = model[w[21:17]];
        b   = model[w[16:12]];
        lit = {{52{w[11]}}, w[11:0]};
        ok  = 1'b1;
        case (w[31:27])
            5'b11000: r = a + b;
            5'b11001: r = model[rd] + lit;
            5'b11010: r = a - b;
            5'b11011: r = model[rd] - lit;
            5'b11100: r = a * b;
            5'b00000: r = a & b;
            5'b00001: r = a | b;
            5'b00010: r = a ^ b;
            5'b00011: r = ~a;
            5'b00100: r = (b >= 64) ? 64'd0 : a >> b[5:0];
            5'b00101: r = (lit >= 64) ? 64'd0 : a >> lit[5:0];
            5'b00110: r = (b >= 64) ? 64'd0 : a << b[5:0];
            5'b00111: r = (lit >= 64) ? 64'd0 : a << lit[5:0];
            5'b10001: r = a;
            5'b10010: r = {model[rd][63:12], w[11:0]};
            default:  ok = 1'b0;
        endcase
        prog.push_back(w);
        // illegal words leave no trace
        if (ok) begin
            model[rd] = r;
            exp_wb.push_back('{rd: rd, value: r});
            exp_op.push_back(tinker_pkg::opcode_e'(w[31:27]));
        end
    endfunction

    // full 64-bit value from mov_l and five 12-bit shift steps
    function automatic void load_reg(input int r, input logic [63:0] v);
        queue_instr(enc(tinker_pkg::op_mov_l, r, 0, 0, {8'd0, v[63:60]}));
        for (int s = 48; s >= 0; s -= 12) begin
            queue_instr(enc(tinker_pkg::op_shftli, r, r, 0, 12'd12));
            queue_instr(enc(tinker_pkg::op_mov_l, r, 0, 0, v[s +: 12]));
        end
    endfunction

    // called right after a rising edge
    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!instr_ready) begin
            n++;
            if (n > TIMEOUT) run_error("timeout waiting for instr_ready");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_all();
        @(posedge clk);
        foreach (prog[i]) begin
            instr_valid <= 1'b1;
            instr       <= prog[i];
            wait_accept();
        end
        instr_valid <= 1'b0;
    endtask

    // in stall mode wb_ready is high about one cycle in four
    task automatic recv_all(input bit stall);
        int                  n;
        tinker_pkg::wb_t     exp;
        tinker_pkg::opcode_e eop;
        while (exp_wb.size() > 0) begin
            n = 0;
            @(negedge clk);
            while (!(wb_valid && wb_ready)) begin
                n++;
                if (n > TIMEOUT) run_error("timeout waiting for a write-back");
                @(posedge clk);
                wb_ready <= stall ? ($urandom_range(3) == 0) : 1'b1;
                @(negedge clk);
            end
            exp = exp_wb.pop_front();
            eop = exp_op.pop_front();
            check_trace('{op: eop, value: wb.value}, '{op: eop, value: exp.value});
            check_wb(wb, exp);
            @(posedge clk);
            wb_ready <= stall ? ($urandom_range(3) == 0) : 1'b1;
        end
        wb_ready <= 1'b1;
    endtask

    task automatic run_queued(input bit stall);
        fork
            send_all();
            recv_all(stall);
        join
        @(negedge clk);
        if (wb_valid) run_error("extra write-back after the last expected result");
        prog.delete();
    endtask

    // idle handshake, then literals into zeroed registers
    task automatic test_reset_mov_l();
        @(negedge clk);
        if (wb_valid !== 1'b0 || instr_ready !== 1'b1) begin
            run_error("handshake outputs not idle after reset");
        end
        for (int r = 1; r < 5; r++) begin
            queue_instr(enc(tinker_pkg::op_mov_l, r, 0, 0, (r == 1) ? 12'hfff : 12'($urandom)));
        end
        run_queued(1'b0);
    endtask

    task automatic test_arith();
        for (int r = 1; r < 5; r++) begin
            load_reg(r, {$urandom, $urandom});
        end
        for (int i = 0; i < 15; i++) begin
            queue_instr(enc(all_ops[i % 5], $urandom_range(1, 6), $urandom_range(1, 4),
                            $urandom_range(1, 4), 12'($urandom)));
        end
        run_queued(1'b0);
    endtask

    // r3..r5 hold 5, 64, 70 as shift amounts
    task automatic test_logic_shift();
        logic [11:0] lits [4] = '{12'd7, 12'd64, 12'd100, 12'hfff};
        load_reg(1, {$urandom, $urandom});
        load_reg(2, {$urandom, $urandom});
        load_reg(3, 64'd5);
        load_reg(4, 64'd64);
        load_reg(5, 64'd70);
        for (int i = 0; i < 32; i++) begin
            queue_instr(enc(all_ops[5 + i % 8], 6 + i % 4, 1 + i % 2, 2 + i / 8, lits[i / 8]));
        end
        run_queued(1'b0);
    endtask

    // each op reads the rd written just before it
    task automatic test_chain();
        tinker_pkg::opcode_e op;
        int                  prev;
        int                  rd;
        prev = 1;
        for (int i = 0; i < 16; i++) begin
            op = all_ops[$urandom_range(14)];
            rd = (op inside {tinker_pkg::op_addi, tinker_pkg::op_subi, tinker_pkg::op_mov_l})
                 ? prev : $urandom_range(31);
            queue_instr(enc(op, rd, prev, prev, 12'($urandom)));
            prev = rd;
        end
        run_queued(1'b0);
    endtask

    task automatic test_stall();
        for (int i = 0; i < 24; i++) begin
            queue_instr(enc(all_ops[$urandom_range(14)], $urandom_range(31),
                            $urandom_range(31), $urandom_range(31), 12'($urandom)));
        end
        run_queued(1'b1);
    endtask

    // two unused opcodes between legal ones
    task automatic test_illegal();
        queue_instr(enc(tinker_pkg::op_mov_l, 9, 0, 0, 12'h5a3));
        queue_instr({5'b01000, 27'($urandom)});
        queue_instr({5'b11111, 27'($urandom)});
        queue_instr(enc(tinker_pkg::op_add, 10, 9, 9, 12'd0));
        run_queued(1'b0);
    endtask

    initial begin
        void'($urandom(79455));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        wb_ready    = 1'b1;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset_mov_l();
        test_arith();
        test_logic_shift();
        test_chain();
        test_stall();
        test_illegal();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verif
src/tinker_pkg.sv
src/instr_decoder.sv
src/op_fifo.sv
src/reg_file.sv
src/exec_unit.sv
src/tinker_exec_top.sv
verif/tb_tinker_exec.sv
